// ==== logic/iwmPkg.sv ====
// iwmPkg: disk address width, drive sense register codes, strobe command codes, IWM write byte union
package iwmPkg;

	localparam int diskAddrWidth = 22; // byte address into the disk image memory

	// drive sense registers, selected by {CA2, CA1, CA0, SEL}
	localparam logic [3:0] senseDirection    = 4'b0000; // head step direction, 1 is inward
	localparam logic [3:0] senseDiskIn       = 4'b0001; // 0 when a disk is in the drive
	localparam logic [3:0] senseStepping     = 4'b0010; // 0 while the head settles
	localparam logic [3:0] senseWriteProtect = 4'b0011; // never protected here
	localparam logic [3:0] senseMotorOn      = 4'b0100; // 0 when the spindle runs
	localparam logic [3:0] senseTrack0       = 4'b0101; // 0 with the head on track 0
	localparam logic [3:0] senseSides        = 4'b1001; // 1 for a two-sided drive
	// every other code reads back 1

	// strobe commands, selected by {CA1, CA0, SEL} with CA2 as the argument
	localparam logic [2:0] cmdDirection = 3'b000; // CA2=1 steps inward
	localparam logic [2:0] cmdStep      = 3'b010; // move one track
	localparam logic [2:0] cmdMotor     = 3'b100; // CA2=0 starts the motor
	localparam logic [2:0] cmdEject     = 3'b110; // CA2=1 ejects

	// IWM mode register layout, low five bits of the written byte
	typedef struct packed {
		logic [2:0] unused;
		logic       clockSpeed;    // 1 = 8 MHz
		logic       bitCellTime;   // 1 = 2 us cells for 3.5" drives
		logic       motorOffTimer; // 1 = no motor-off delay
		logic       handshakeMode; // 1 = asynchronous
		logic       latchMode;     // 1 = latch held for full byte time
	} iwmModeBits;

	// byte written under Q7=Q6=1
	// becomes the mode register with both drives off, write data otherwise
	typedef union packed {
		logic [7:0] raw;
		iwmModeBits mode;
	} iwmWriteByte;

endpackage

// ==== logic/iwm.sv ====
// iwm controller: state switch decode, register read mux, mode and write-data registers, read latch
`timescale 1ns/10ps

module iwm import iwmPkg::*; (
	input  logic        clk8,
	input  logic        _reset,
	input  logic        selectIWM,
	input  logic        _cpuRW,       // 0 on a CPU write
	input  logic        _cpuLDS,
	input  logic [15:0] dataIn,
	input  logic [3:0]  cpuAddrRegHi, // [3:1] switch number, [0] new value
	input  logic        senseInt,
	input  logic        senseExt,
	input  logic [7:0]  readDataInt,
	input  logic [7:0]  readDataExt,
	input  logic        newByteReadyInt,
	input  logic        newByteReadyExt,
	output logic [15:0] dataOut,
	output logic        ca0,
	output logic        ca1,
	output logic        ca2,
	output logic        lstrb,
	output logic        enableInt,
	output logic        enableExt
);

	localparam int clearDelay = 14; // latch clear, in clk8 cycles after a valid read ends

	logic q6, q7, selectExt;          // remaining state switches
	logic ca0Next, ca1Next, ca2Next, lstrbNext;
	logic enableIntNext, enableExtNext, selectExtNext, q6Next, q7Next;
	logic [4:0] mode;
	logic [7:0] writeData;            // held only, no serial write path
	logic [7:0] readLatch;
	logic [3:0] clearTimer;
	logic validReadPrev;
	logic [7:0] dataOutLo;
	iwmWriteByte writeByte;

	wire access   = selectIWM && !_cpuLDS;
	wire cpuRead  = access && _cpuRW;
	wire cpuWrite = access && !_cpuRW;

	// drive chosen by the select switch feeds the latch
	wire [7:0] readData     = selectExt ? readDataExt : readDataInt;
	wire       newByteReady = selectExt ? newByteReadyExt : newByteReadyInt;

	assign writeByte.raw = dataIn[7:0];

	// every access, read or write, flips one switch
	always_comb begin
		ca0Next       = ca0;
		ca1Next       = ca1;
		ca2Next       = ca2;
		lstrbNext     = lstrb;
		enableIntNext = enableInt;
		enableExtNext = enableExt;
		selectExtNext = selectExt;
		q6Next        = q6;
		q7Next        = q7;
		if (access) begin
			case (cpuAddrRegHi[3:1])
				3'd0: ca0Next = cpuAddrRegHi[0];
				3'd1: ca1Next = cpuAddrRegHi[0];
				3'd2: ca2Next = cpuAddrRegHi[0];
				3'd3: lstrbNext = cpuAddrRegHi[0];
				3'd4: begin // enable goes to the drive selected right now
					if (selectExt)
						enableExtNext = cpuAddrRegHi[0];
					else
						enableIntNext = cpuAddrRegHi[0];
				end
				3'd5: selectExtNext = cpuAddrRegHi[0];
				3'd6: q6Next = cpuAddrRegHi[0];
				default: q7Next = cpuAddrRegHi[0];
			endcase
		end
	end

	always_ff @(posedge clk8) begin
		if (!_reset) begin
			ca0       <= 1'b0;
			ca1       <= 1'b0;
			ca2       <= 1'b0;
			lstrb     <= 1'b0;
			enableInt <= 1'b0;
			enableExt <= 1'b0;
			selectExt <= 1'b0;
			q6        <= 1'b0;
			q7        <= 1'b0;
		end else begin
			ca0       <= ca0Next;
			ca1       <= ca1Next;
			ca2       <= ca2Next;
			lstrb     <= lstrbNext;
			enableInt <= enableIntNext;
			enableExt <= enableExtNext;
			selectExt <= selectExtNext;
			q6        <= q6Next;
			q7        <= q7Next;
		end
	end

	// read mux sees the switch change of the access in progress
	always_comb begin
		case ({q7Next, q6Next})
			2'b00: dataOutLo = readLatch; // bit 7 marks a valid byte
			2'b01: dataOutLo = {selectExtNext ? senseExt : senseInt, 1'b0,
				enableIntNext & enableExtNext, mode}; // status
			2'b10: dataOutLo = 8'hC0; // handshake, buffer empty and no underrun
			default: dataOutLo = 8'h00;
		endcase
	end
	assign dataOut = {8'hBE, dataOutLo};

	// Q7/Q6 writes go to mode while both drives are off
	always_ff @(posedge clk8) begin
		if (!_reset)
			mode <= 5'd0;
		else if (cpuWrite && q7Next && q6Next && !(enableInt || enableExt))
			mode <= {writeByte.mode.clockSpeed, writeByte.mode.bitCellTime,
				writeByte.mode.motorOffTimer, writeByte.mode.handshakeMode,
				writeByte.mode.latchMode};
	end

	always_ff @(posedge clk8) begin
		if (cpuWrite && q7Next && q6Next && (enableInt || enableExt))
			writeData <= writeByte.raw; // byte to be written while a drive runs
	end

	// a data register read that returned bit 7 set
	wire dataRead = cpuRead && !q7Next && !q6Next && readLatch[7];

	always_ff @(posedge clk8) begin
		if (!_reset) begin
			readLatch     <= 8'h00;
			clearTimer    <= 4'd0;
			validReadPrev <= 1'b0;
		end else begin
			validReadPrev <= dataRead;
			if (newByteReady) begin
				readLatch  <= readData;
				clearTimer <= 4'd0; // a fresh byte cancels a pending clear
			end else if (validReadPrev && !cpuRead) begin
				clearTimer <= 4'(clearDelay); // read just ended
			end else if (clearTimer != 4'd0) begin
				clearTimer <= clearTimer - 4'd1;
				if (clearTimer == 4'd1)
					readLatch <= 8'h00;
			end
		end
	end

endmodule

// ==== logic/floppy.sv ====
// floppy drive model: sense decode, strobe commands, head position, track byte fetch engine
`timescale 1ns/10ps

module floppy import iwmPkg::*; #(
	parameter int byteCycles    = 16, // cycles between byte fetches
	parameter int bytesPerTrack = 32,
	parameter int trackCount    = 80
) (
	input  logic                     clk8,
	input  logic                     _reset,
	input  logic                     ca0,
	input  logic                     ca1,
	input  logic                     ca2,
	input  logic                     SEL,
	input  logic                     lstrb,
	input  logic                     enable,
	input  logic                     insertDisk,
	input  logic                     diskSides,   // 1 for a two-sided disk
	input  logic                     dskReadAck,
	input  logic [7:0]               dskReadData,
	output logic                     sense,
	output logic [7:0]               readData,
	output logic                     newByteReady,
	output logic                     diskEject,
	output logic                     dskReadReq,
	output logic [diskAddrWidth-1:0] dskReadAddr
);

	localparam int trackWidth  = $clog2(trackCount);
	localparam int offsetWidth = $clog2(bytesPerTrack + 1);
	localparam int waitWidth   = $clog2(byteCycles + 1);
	localparam int settleCycles = 4; // stepping sense stays low this long

	typedef enum logic [1:0] {
		fetchIdle,
		fetchRequest, // req high, waiting for ack
		fetchRelease, // req dropped, waiting for ack to fall
		fetchDeliver  // one cycle newByteReady
	} fetchState;

	fetchState state;
	logic [trackWidth-1:0]  track;
	logic [offsetWidth-1:0] offset;
	logic [waitWidth-1:0]   waitCount;
	logic [2:0]             settleCount;
	logic direction;       // 1 steps inward
	logic motorOn;
	logic inserted;
	logic lstrbPrev, insertPrev;

	wire strobe  = lstrb && !lstrbPrev && enable; // commands act on the rising edge
	wire running = enable && motorOn && inserted;
	wire side    = diskSides && SEL;
	wire [3:0] regSelect = {ca2, ca1, ca0, SEL};
	wire [2:0] command   = {ca1, ca0, SEL};

	// address = ((track * 2) + side) * bytesPerTrack + offset
	wire [diskAddrWidth-1:0] fetchAddr =
		((diskAddrWidth'(track) << 1) + diskAddrWidth'(side))
		* diskAddrWidth'(bytesPerTrack) + diskAddrWidth'(offset);

	always_comb begin
		case (regSelect)
			senseDirection:    sense = direction;
			senseDiskIn:       sense = !inserted;
			senseStepping:     sense = (settleCount == 3'd0);
			senseWriteProtect: sense = 1'b1;
			senseMotorOn:      sense = !motorOn;
			senseTrack0:       sense = (track != '0);
			senseSides:        sense = diskSides;
			default:           sense = 1'b1;
		endcase
	end

	// head, motor and media state
	always_ff @(posedge clk8) begin
		if (!_reset) begin
			track       <= '0;
			direction   <= 1'b0;
			motorOn     <= 1'b0;
			inserted    <= 1'b0;
			diskEject   <= 1'b0;
			settleCount <= 3'd0;
			lstrbPrev   <= 1'b0;
			insertPrev  <= 1'b0;
		end else begin
			lstrbPrev  <= lstrb;
			insertPrev <= insertDisk;
			diskEject  <= 1'b0;
			if (settleCount != 3'd0)
				settleCount <= settleCount - 3'd1;
			if (insertDisk && !insertPrev)
				inserted <= 1'b1;
			if (strobe) begin
				case (command)
					cmdDirection: direction <= ca2;
					cmdStep: begin
						if (direction && track != trackWidth'(trackCount - 1))
							track <= track + 1'b1;
						else if (!direction && track != '0)
							track <= track - 1'b1;
						settleCount <= 3'(settleCycles);
					end
					cmdMotor: motorOn <= !ca2;
					cmdEject: begin
						if (ca2) begin // eject wins over a same-cycle insert
							diskEject <= 1'b1;
							inserted  <= 1'b0;
							motorOn   <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// fetch engine, one four-phase req/ack at a time
	always_ff @(posedge clk8) begin
		if (!_reset) begin
			state      <= fetchIdle;
			waitCount  <= '0;
			offset     <= '0;
			dskReadReq <= 1'b0;
		end else begin
			case (state)
				fetchIdle: begin
					if (!running)
						waitCount <= '0;
					else if (waitCount == waitWidth'(byteCycles - 1)) begin
						dskReadReq <= 1'b1;
						state      <= fetchRequest;
					end else
						waitCount <= waitCount + 1'b1;
				end
				fetchRequest: begin
					if (dskReadAck) begin
						dskReadReq <= 1'b0;
						state      <= fetchRelease;
					end
				end
				fetchRelease: begin
					if (!dskReadAck)
						state <= fetchDeliver;
				end
				default: begin // deliver, restart the cadence here
					waitCount <= '0;
					if (offset == offsetWidth'(bytesPerTrack - 1))
						offset <= '0;
					else
						offset <= offset + 1'b1;
					state <= fetchIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk8) begin
		if (state == fetchIdle && running && waitCount == waitWidth'(byteCycles - 1))
			dskReadAddr <= fetchAddr; // held stable for the whole request
		if (state == fetchRequest && dskReadAck)
			readData <= dskReadData;
	end

	assign newByteReady = (state == fetchDeliver);

endmodule

// ==== logic/floppySubsystem.sv ====
// floppySubsystem top level: IWM controller with internal and external 3.5" drive models
`timescale 1ns/10ps

module floppySubsystem import iwmPkg::*; #(
	parameter int byteCycles    = 16,
	parameter int bytesPerTrack = 32,
	parameter int trackCount    = 80
) (
	input  logic                     clk8,
	input  logic                     _reset,
	input  logic                     selectIWM,
	input  logic                     _cpuRW,
	input  logic                     _cpuLDS,
	input  logic [15:0]              dataIn,
	input  logic [3:0]               cpuAddrRegHi,
	input  logic                     SEL,          // head select from the VIA
	input  logic [1:0]               insertDisk,   // [0] internal, [1] external
	input  logic [1:0]               diskSides,
	input  logic                     dskReadAckInt,
	input  logic                     dskReadAckExt,
	input  logic [7:0]               dskReadData,  // shared by both drives
	output logic [15:0]              dataOut,
	output logic [1:0]               diskEject,
	output logic                     dskReadReqInt,
	output logic [diskAddrWidth-1:0] dskReadAddrInt,
	output logic                     dskReadReqExt,
	output logic [diskAddrWidth-1:0] dskReadAddrExt
);

	logic ca0, ca1, ca2, lstrb;
	logic enableInt, enableExt;
	logic senseInt, senseExt;
	logic [7:0] readDataInt, readDataExt;
	logic newByteReadyInt, newByteReadyExt;

	iwm controller (
		.clk8, ._reset, .selectIWM, ._cpuRW, ._cpuLDS, .dataIn, .cpuAddrRegHi,
		.senseInt, .senseExt, .readDataInt, .readDataExt,
		.newByteReadyInt, .newByteReadyExt,
		.dataOut, .ca0, .ca1, .ca2, .lstrb, .enableInt, .enableExt
	);

	floppy #(.byteCycles(byteCycles), .bytesPerTrack(bytesPerTrack),
		.trackCount(trackCount)) floppyInt (
		.clk8, ._reset, .ca0, .ca1, .ca2, .SEL, .lstrb,
		.enable(enableInt), .insertDisk(insertDisk[0]), .diskSides(diskSides[0]),
		.dskReadAck(dskReadAckInt), .dskReadData,
		.sense(senseInt), .readData(readDataInt), .newByteReady(newByteReadyInt),
		.diskEject(diskEject[0]), .dskReadReq(dskReadReqInt), .dskReadAddr(dskReadAddrInt)
	);

	floppy #(.byteCycles(byteCycles), .bytesPerTrack(bytesPerTrack),
		.trackCount(trackCount)) floppyExt (
		.clk8, ._reset, .ca0, .ca1, .ca2, .SEL, .lstrb,
		.enable(enableExt), .insertDisk(insertDisk[1]), .diskSides(diskSides[1]),
		.dskReadAck(dskReadAckExt), .dskReadData,
		.sense(senseExt), .readData(readDataExt), .newByteReady(newByteReadyExt),
		.diskEject(diskEject[1]), .dskReadReq(dskReadReqExt), .dskReadAddr(dskReadAddrExt)
	);

endmodule

// ==== testbench/diskMemory.sv ====
// diskMemory: req/ack responder for both drives, random latency, data taken from the address
`timescale 1ns/10ps

module diskMemory import iwmPkg::*; (
	input  logic                     clk8,
	input  logic                     reqInt,
	input  logic [diskAddrWidth-1:0] addrInt,
	output logic                     ackInt,
	input  logic                     reqExt,
	input  logic [diskAddrWidth-1:0] addrExt,
	output logic                     ackExt,
	output logic [7:0]               data,        // shared by both drives
	output logic [diskAddrWidth-1:0] lastAddrInt,
	output logic [diskAddrWidth-1:0] lastAddrExt
);

	integer seed = 32'hbc10fffc;

	// one transfer, ack 1 to 4 cycles after req is seen, dropped once req falls
	task automatic serve(input logic ext);
		logic [diskAddrWidth-1:0] addr;
		int delay;
		addr = ext ? addrExt : addrInt;
		if (ext)
			lastAddrExt = addr;
		else
			lastAddrInt = addr;
		delay = 1 + ($unsigned($random(seed)) % 4);
		repeat (delay - 1) @(posedge clk8);
		#10;
		data = {1'b1, addr[6:0]}; // bit 7 marks a valid disk byte
		if (ext)
			ackExt = 1'b1;
		else
			ackInt = 1'b1;
		do
			@(posedge clk8);
		while (ext ? reqExt : reqInt);
		#10;
		ackInt = 1'b0;
		ackExt = 1'b0;
	endtask

	initial begin
		ackInt      = 1'b0;
		ackExt      = 1'b0;
		data        = 8'h00;
		lastAddrInt = '0;
		lastAddrExt = '0;
		forever begin
			@(posedge clk8);
			if (reqInt)
				serve(1'b0); // internal drive first
			else if (reqExt)
				serve(1'b1);
		end
	end

endmodule

// ==== testbench/iwmTb.sv ====
// iwmTb: clock and reset, case file interpreter, bus tasks, fetch and eject monitors, watchdog
`timescale 1ns/10ps

module iwmTb import iwmPkg::*; ();

	localparam int byteCycles    = 16; // DUT runs with its default parameters
	localparam int bytesPerTrack = 32;
	localparam int maxCases      = 64;

	logic clk8, _reset, selectIWM, _cpuRW, _cpuLDS, SEL;
	logic [15:0] dataIn, dataOut;
	logic [3:0] cpuAddrRegHi;
	logic [1:0] insertDisk, diskSides, diskEject;
	logic dskReadReqInt, dskReadReqExt, dskReadAckInt, dskReadAckExt;
	logic [7:0] dskReadData;
	logic [diskAddrWidth-1:0] dskReadAddrInt, dskReadAddrExt, lastAddrInt, lastAddrExt;
	logic [23:0] cases [maxCases]; // op, switch, value, mask
	int caseCount = 0;
	int valueErrors = 0;
	int eventErrors = 0;
	int fetchCount = 0;
	int ejectCount = 0;
	int nextOffset = 0;   // offset the next internal fetch must carry
	logic reqPrev = 1'b0;
	logic extSeen = 1'b0; // external drive is never enabled

	floppySubsystem dut (.*);

	diskMemory memory (
		.clk8, .reqInt(dskReadReqInt), .addrInt(dskReadAddrInt), .ackInt(dskReadAckInt),
		.reqExt(dskReadReqExt), .addrExt(dskReadAddrExt), .ackExt(dskReadAckExt),
		.data(dskReadData), .lastAddrInt, .lastAddrExt
	);

	initial begin
		clk8 = 1'b0;
		forever #50 clk8 = ~clk8; // 100 ns period
	end

	// each internal request steps the byte offset by one, whatever the track
	always @(posedge clk8) begin
		if (dskReadReqInt && !reqPrev) begin
			fetchCount++;
			if (int'(dskReadAddrInt % bytesPerTrack) != nextOffset) begin
				$display("** Error at %0t: dskReadAddrInt offset expected %0d, got %0d",
					$time, nextOffset, dskReadAddrInt % bytesPerTrack);
				valueErrors++;
			end
			nextOffset = (nextOffset + 1) % bytesPerTrack;
		end
		if (diskEject[0])
			ejectCount++; // one-cycle pulse
		if (!extSeen && (diskEject[1] || dskReadReqExt || lastAddrExt != '0)) begin
			$display("external drive ejected or fetched although it was never enabled");
			eventErrors++;
			extSeen = 1'b1;
		end
		reqPrev = dskReadReqInt;
	end

	// one CPU access: driven after the edge, sampled late in the cycle
	task automatic busCycle(input logic write, input logic [3:0] addr, input logic [7:0] data,
		output logic [15:0] result);
		@(posedge clk8);
		#10;
		selectIWM    = 1'b1;
		_cpuLDS      = 1'b0;
		_cpuRW       = !write;
		cpuAddrRegHi = addr;
		dataIn       = {8'h00, data};
		#80 result = dataOut;
		@(posedge clk8);
		#10;
		selectIWM = 1'b0;
		_cpuLDS   = 1'b1;
		_cpuRW    = 1'b1;
	endtask

	task automatic checkData(input logic [15:0] actual, input logic [7:0] expected,
		input logic [7:0] mask);
		if (actual[15:8] != 8'hBE || ((actual[7:0] ^ expected) & mask) != 8'h00) begin
			$display("** Error at %0t: dataOut expected BE%h (mask %h), got %h",
				$time, expected, mask, actual);
			valueErrors++;
		end
	endtask

	task automatic setLines(input logic [3:0] lines); // {CA2, CA1, CA0, SEL}
		logic [15:0] unused;
		busCycle(1'b1, {3'd0, lines[1]}, 8'h00, unused);
		busCycle(1'b1, {3'd1, lines[2]}, 8'h00, unused);
		busCycle(1'b1, {3'd2, lines[3]}, 8'h00, unused);
		SEL = lines[0];
	endtask

	// poll the data register until bit 7 shows, byte must follow the memory rule
	task automatic awaitByte();
		logic [15:0] result;
		int polls;
		polls  = 0;
		result = 16'h0000;
		while (!result[7] && polls < 8 * byteCycles) begin
			busCycle(1'b0, 4'hC, 8'h00, result);
			polls++;
		end
		if (!result[7]) begin
			$display("no valid byte reached the data register after %0d reads", polls);
			eventErrors++;
		end else
			checkData(result, {1'b1, lastAddrInt[6:0]}, 8'hFF);
	endtask

	task automatic awaitFetches(input int count);
		int target;
		int cycles;
		target = fetchCount + count;
		cycles = 0;
		while (fetchCount < target && cycles < count * 8 * byteCycles) begin
			@(posedge clk8);
			#10;
			cycles++;
		end
		if (fetchCount < target) begin
			$display("internal drive made no new fetch request within %0d cycles", cycles);
			eventErrors++;
		end
	endtask

	// address = ((track * 2) + side) * bytesPerTrack + offset
	task automatic checkTrack(input int track);
		logic [diskAddrWidth-1:0] expected;
		expected = (track * 2 + (SEL & diskSides[0])) * bytesPerTrack
			+ lastAddrInt % bytesPerTrack;
		if (lastAddrInt != expected) begin
			$display("** Error at %0t: dskReadAddrInt expected %h, got %h",
				$time, expected, lastAddrInt);
			valueErrors++;
		end
	endtask

	initial begin
		logic [15:0] result;
		logic [23:0] entry;
		int index;
		selectIWM    = 1'b0;
		_cpuRW       = 1'b1;
		_cpuLDS      = 1'b1;
		dataIn       = 16'h0000;
		cpuAddrRegHi = 4'h0;
		SEL          = 1'b0;
		insertDisk   = 2'b00;
		diskSides    = 2'b01; // internal two-sided, external single
		_reset       = 1'b0;
		for (index = 0; index < maxCases; index++)
			cases[index] = 24'h0;
		$readmemh("testbench/iwmCases.txt", cases);
		while (caseCount < maxCases && cases[caseCount][23:20] != 4'h0)
			caseCount++;
		if (caseCount == 0) begin
			$display("case file is missing or holds no operations");
			eventErrors++;
		end
		repeat (3) @(posedge clk8);
		#10 _reset = 1'b1;
		for (index = 0; index < caseCount; index++) begin
			entry = cases[index];
			case (entry[23:20])
				4'h1: busCycle(1'b1, entry[19:16], entry[15:8], result);
				4'h2: begin
					busCycle(1'b0, entry[19:16], 8'h00, result);
					checkData(result, entry[15:8], entry[7:0]);
				end
				4'h3: setLines(entry[11:8]);
				4'h4: begin
					setLines(entry[11:8]);
					busCycle(1'b1, 4'h7, 8'h00, result); // lstrb rise runs the command
					busCycle(1'b1, 4'h6, 8'h00, result);
				end
				4'h5: begin
					@(posedge clk8);
					#10 insertDisk[entry[16]] = entry[8];
				end
				4'h6: awaitByte();
				4'h7: awaitFetches(entry[15:8]);
				4'h8: checkTrack(entry[15:8]);
				4'h9: begin
					repeat (entry[15:8]) @(posedge clk8);
					#10;
				end
				4'hA: if (ejectCount != entry[15:8]) begin
					$display("** Error at %0t: diskEject pulses expected %0d, got %0d",
						$time, entry[15:8], ejectCount);
					valueErrors++;
				end
				default: begin
					$display("unknown operation %h in case line %0d", entry[23:20], index);
					eventErrors++;
				end
			endcase
		end
		$display("value errors: %0d, event errors: %0d", valueErrors, eventErrors);
		if (valueErrors == 0 && eventErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog sized from the number of case lines
	initial begin
		@(posedge clk8);
		repeat (caseCount * 8 * byteCycles + 200) @(posedge clk8);
		$display("watchdog expired before the case list finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== testbench/iwmCases.txt ====
// op_switch_value_mask: 1 write, 2 read and compare, 3 set CA2 CA1 CA0 SEL, 4 strobe command,
// 5 insert disk, 6 await valid byte, 7 await fetches, 8 check track, 9 idle, A eject count
2_D_00_FF // status after reset, direction sense reads 0
2_C_00_FF // no byte latched
2_D_00_FF
1_F_15_00 // Q7/Q6 write with both drives off sets mode
1_E_00_00 // q7 off
2_D_15_FF
1_9_00_00 // enable internal drive
1_F_0A_00 // now held as write data
1_E_00_00
2_D_15_FF // mode unchanged
3_0_01_00 // disk-in sense
2_D_95_FF // drive empty
5_0_01_00 // insert internal disk
2_D_15_FF
3_0_05_00 // track 0 sense
2_D_15_FF
3_0_04_00 // motor sense
2_D_95_FF // motor off
4_0_04_00 // motor on
2_D_15_FF
3_0_09_00 // sides sense
2_D_95_FF // two-sided
6_0_00_00 // first byte against the memory rule
3_0_00_00 // side 0
7_0_01_00
8_0_00_00
3_0_01_00 // side 1 adds one track worth of bytes
7_0_01_00
8_0_00_00
4_0_08_00 // direction inward
4_0_02_00 // step
3_0_05_00
2_D_95_FF // off track 0
7_0_01_00
8_0_01_00
9_0_28_00 // let the latch refill
4_0_0E_00 // eject, motor stops
A_0_01_00
3_0_01_00
2_D_95_FF // disk-in sense back to 1
9_0_14_00
2_C_80_80 // valid byte still latched
9_0_14_00
2_C_00_FF // cleared after the read

// ==== all.f ====
logic/iwmPkg.sv
logic/iwm.sv
logic/floppy.sv
logic/floppySubsystem.sv
testbench/diskMemory.sv
testbench/iwmTb.sv

// ==== Bender.yml ====
package:
  name: floppy_iwm

sources:
  - files:
      - logic/iwmPkg.sv
      - logic/iwm.sv
      - logic/floppy.sv
      - logic/floppySubsystem.sv
  - target: simulation
    files:
      - testbench/diskMemory.sv
      - testbench/iwmTb.sv
